// File: tb.f
verilog/lot_pkg.sv
verilog/elevator_pkg.sv
verilog/order_queue.sv
verilog/slot_allocator.sv
verilog/fee_meter_bank.sv
verilog/elevator_controller.sv
verilog/parking_tower.sv
verification/tb_parking_tower.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the parking tower testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_parking_tower \
	--Mdir obj_dir -o sim_parking_tower
./obj_dir/sim_parking_tower > sim.log 2>&1 || true
cat sim.log
if grep -qx '>>> PASS' sim.log; then
	exit 0
fi
exit 1

// File: verification/tb_parking_tower.sv
/* Parking tower testbench: clock, reset, watchdog, value check and
   directed tests for allocation, queueing, fees and bad orders */
`timescale 1ns/1ps

module tb_parking_tower;

	localparam int CLOCK_PERIOD = 10;
	localparam int PHASE_LIMIT  = 40;  // Cycles allowed for busy to rise, or to fall
	// About 46 trips of up to 20 cycles plus a 210 cycle park, so near 12000 ns, with margin
	localparam int WATCHDOG_NS  = 20000;

	logic            clock;
	logic            reset;
	lot_pkg::plate_t plate;
	logic            in_mode;
	logic            out_mode;
	logic            busy, reject, car_out, queue_full;
	lot_pkg::plate_t exit_plate;
	lot_pkg::fee_t   fee;
	lot_pkg::floor_t current_floor;
	logic [3:0]      free_sedan, free_suv;
	integer          seed;

	parking_tower dut0 (
		.clock(clock), .reset(reset), .plate(plate), .in_mode(in_mode), .out_mode(out_mode),
		.busy(busy), .reject(reject), .car_out(car_out), .exit_plate(exit_plate), .fee(fee),
		.current_floor(current_floor), .free_sedan(free_sedan), .free_suv(free_suv),
		.queue_full(queue_full)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
			abort_run();
		end
	endtask

	// Nibble 0 picks a random regular class; idx keeps plates of one test distinct
	task automatic make_plate(input logic [3:0] nibble, input int idx, input logic odd,
	                          output lot_pkg::plate_t p);
		logic [31:0] r;
		r = $random(seed);
		if (nibble == 4'd0)
			p = {1'b0, r[14:12] | 3'b001, r[11:5], idx[3:0], odd};
		else
			p = {nibble, r[11:5], idx[3:0], odd};
	endtask

	task automatic send_order(input lot_pkg::order_kind_t kind, input lot_pkg::plate_t p);
		@(posedge clock);
		in_mode  <= (kind == lot_pkg::order_in);
		out_mode <= (kind == lot_pkg::order_out);
		plate    <= p;
		@(posedge clock);
		in_mode  <= 1'b0;
		out_mode <= 1'b0;
	endtask

	// Waits for busy to rise and fall, noting the top floor and any car_out
	task automatic track_trip(output lot_pkg::floor_t peak, output logic seen_out,
	                          output lot_pkg::plate_t out_plate, output lot_pkg::fee_t out_fee);
		int waited;
		peak      = '0;
		seen_out  = 1'b0;
		out_plate = '0;
		out_fee   = '0;
		waited    = 0;
		@(negedge clock);
		while (!busy) begin
			if (reject) begin
				$display("Order was rejected where a trip was expected");
				abort_run();
			end
			waited++;
			if (waited > PHASE_LIMIT) begin
				$display("Elevator did not start a trip within %0d cycles", PHASE_LIMIT);
				abort_run();
			end
			@(negedge clock);
		end
		waited = 0;
		while (busy) begin
			if (current_floor > peak)
				peak = current_floor;
			if (car_out) begin  // Plate and fee only valid in this cycle
				seen_out  = 1'b1;
				out_plate = exit_plate;
				out_fee   = fee;
			end
			waited++;
			if (waited > PHASE_LIMIT) begin
				$display("Elevator trip did not end within %0d cycles", PHASE_LIMIT);
				abort_run();
			end
			@(negedge clock);
		end
	endtask

	task automatic expect_reject(input string what);
		int waited;
		waited = 0;
		@(negedge clock);
		while (!reject) begin
			waited++;
			if (busy || waited > 4) begin
				$display("Missing reject for %s", what);
				abort_run();
			end
			@(negedge clock);
		end
		@(negedge clock);
		check_value(busy, 0, "busy after a reject");
	endtask

	task automatic park_car(input lot_pkg::plate_t p, input int exp_floor);
		lot_pkg::floor_t peak;
		logic            seen;
		lot_pkg::plate_t op;
		lot_pkg::fee_t   of;
		send_order(lot_pkg::order_in, p);
		track_trip(peak, seen, op, of);
		check_value(peak, exp_floor, "peak floor of an in-trip");
		check_value(seen, 0, "car_out on an in-trip");
	endtask

	task automatic retrieve_car(input lot_pkg::plate_t p, output lot_pkg::fee_t f);
		lot_pkg::floor_t peak;
		logic            seen;
		lot_pkg::plate_t op;
		send_order(lot_pkg::order_out, p);
		track_trip(peak, seen, op, f);
		if (!seen) begin
			$display("Missing car_out for plate %h", p);
			abort_run();
		end
		check_value(op, p, "exit_plate");
	endtask

	task automatic test_reset_state();
		@(negedge clock);
		check_value(current_floor, 0, "current_floor after reset");
		check_value({busy, reject, car_out, queue_full}, 0, "status levels after reset");
		check_value(free_sedan, 6, "free_sedan after reset");
		check_value(free_suv, 8, "free_suv after reset");
	endtask

	task automatic test_park_retrieve();
		lot_pkg::plate_t p;
		lot_pkg::fee_t   f;
		make_plate(4'd0, 1, 1'b0, p);
		park_car(p, 2);
		check_value(free_sedan, 5, "free_sedan with one sedan parked");
		check_value(free_suv, 8, "free_suv with one sedan parked");
		retrieve_car(p, f);
		check_value(free_sedan, 6, "free_sedan after sedan exit");
		make_plate(4'd0, 2, 1'b1, p);
		park_car(p, 1);
		check_value(free_suv, 7, "free_suv with one SUV parked");
		retrieve_car(p, f);
		check_value(free_suv, 8, "free_suv after SUV exit");
	endtask

	// Lowest eligible floor first, left then right, so two cars per floor
	task automatic test_allocation_order();
		lot_pkg::plate_t sedans [6];
		lot_pkg::plate_t suvs [8];
		lot_pkg::plate_t extra;
		lot_pkg::fee_t   f;
		for (int i = 0; i < 6; i++) begin
			make_plate(4'd0, i, 1'b0, sedans[i]);
			park_car(sedans[i], 2 * (i / 2) + 2);
			check_value(free_sedan, 5 - i, "free_sedan while filling");
		end
		make_plate(4'd0, 6, 1'b0, extra);
		send_order(lot_pkg::order_in, extra);
		expect_reject("a seventh sedan");
		for (int i = 0; i < 6; i++)
			retrieve_car(sedans[i], f);
		check_value(free_sedan, 6, "free_sedan after emptying");
		for (int i = 0; i < 8; i++) begin
			make_plate(4'd0, i, 1'b1, suvs[i]);
			park_car(suvs[i], 2 * (i / 2) + 1);
			check_value(free_suv, 7 - i, "free_suv while filling");
		end
		for (int i = 0; i < 8; i++)
			retrieve_car(suvs[i], f);
		check_value(free_suv, 8, "free_suv after emptying");
	endtask

	task automatic test_queueing();
		lot_pkg::plate_t a, b, op;
		lot_pkg::floor_t peak;
		logic            seen;
		lot_pkg::fee_t   f;
		make_plate(4'd0, 10, 1'b0, a);
		make_plate(4'd0, 11, 1'b0, b);
		@(posedge clock);
		in_mode <= 1'b1;
		plate   <= a;
		@(posedge clock);
		plate <= b;
		@(posedge clock);
		in_mode  <= 1'b0;
		out_mode <= 1'b1;
		plate    <= a;
		@(posedge clock);
		out_mode <= 1'b0;
		track_trip(peak, seen, op, f);  // A to floor 2 left
		check_value({peak, seen}, {3'd2, 1'b0}, "first queued trip");
		track_trip(peak, seen, op, f);  // B to floor 2 right
		check_value({peak, seen}, {3'd2, 1'b0}, "second queued trip");
		track_trip(peak, seen, op, f);
		check_value({peak, seen}, {3'd2, 1'b1}, "third queued trip");
		check_value(op, a, "exit_plate of queued out-order");
		check_value(free_sedan, 5, "free_sedan with B still parked");
		retrieve_car(b, f);
		check_value(free_sedan, 6, "free_sedan after queueing test");
	endtask

	task automatic test_fee_rules();
		lot_pkg::plate_t p;
		lot_pkg::fee_t   f;
		make_plate(4'h9, 12, 1'b0, p);
		park_car(p, 2);
		retrieve_car(p, f);
		check_value(f, 0, "handicapped fee");
		make_plate(4'h8, 13, 1'b1, p);
		park_car(p, 1);
		retrieve_car(p, f);
		check_value(f != 0, 1, "hybrid fee is nonzero");
		make_plate(4'd0, 14, 1'b0, p);
		park_car(p, 2);
		retrieve_car(p, f);
		check_value({f != 0, f[0]}, 2'b10, "regular fee is nonzero and even");
		make_plate(4'd0, 15, 1'b1, p);
		park_car(p, 1);
		repeat (210) @(posedge clock);  // 2 per cycle passes 255 long before this
		retrieve_car(p, f);
		check_value(f, 255, "saturated regular fee");
	endtask

	task automatic test_bad_orders();
		lot_pkg::plate_t parked, unknown;
		lot_pkg::fee_t   f;
		make_plate(4'd0, 3, 1'b1, parked);
		make_plate(4'd0, 4, 1'b1, unknown);
		park_car(parked, 1);
		send_order(lot_pkg::order_out, unknown);
		expect_reject("an out-order with an unknown plate");
		send_order(lot_pkg::order_in, '0);
		expect_reject("an in-order with plate 0");
		send_order(lot_pkg::order_out, '0);
		expect_reject("an out-order with plate 0");
		check_value({free_sedan, free_suv}, {4'd6, 4'd7}, "free counts after bad orders");
		retrieve_car(parked, f);
		check_value(free_suv, 8, "free_suv after bad orders test");
	endtask

	initial begin
		seed     = 32'h01ae_a466;
		reset    = 1'b1;
		in_mode  = 1'b0;
		out_mode = 1'b0;
		plate    = '0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		test_reset_state();
		test_park_retrieve();
		test_allocation_order();
		test_queueing();
		test_fee_rules();
		test_bad_orders();
		$display(">>> PASS");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		abort_run();
	end

endmodule

// File: verilog/parking_tower.sv
/* Parking tower top: order queue, spot allocator, fee meters
   and the elevator FSM */
`timescale 1ns/1ps

module parking_tower #(
	parameter int N_FLOORS    = 8,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic            clock,
	input  logic            reset,
	input  lot_pkg::plate_t plate,
	input  logic            in_mode,
	input  logic            out_mode,
	output logic            busy,
	output logic            reject,
	output logic            car_out,
	output lot_pkg::plate_t exit_plate,
	output lot_pkg::fee_t   fee,
	output lot_pkg::floor_t current_floor,
	output logic [3:0]      free_sedan,
	output logic [3:0]      free_suv,
	output logic            queue_full
);

	lot_pkg::order_t                  new_order, head_order;
	logic                             head_valid, pop, found, park, pick;
	lot_pkg::spot_t                   alloc_spot;
	lot_pkg::plate_t [2*N_FLOORS-1:0] occupancy;
	elevator_pkg::trip_t              trip;
	lot_pkg::fee_t                    meter_fee;

	assign new_order.kind  = out_mode ? lot_pkg::order_out : lot_pkg::order_in;
	assign new_order.plate = plate;

	order_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
		.clock(clock), .reset(reset), .push(in_mode | out_mode), .push_order(new_order),
		.pop(pop), .head_order(head_order), .head_valid(head_valid), .full(queue_full)
	);

	slot_allocator #(.N_FLOORS(N_FLOORS)) alloc0 (
		.clock(clock), .reset(reset), .request(head_order), .park(park), .pick(pick),
		.trip(trip), .found(found), .spot(alloc_spot), .occupancy(occupancy),
		.free_sedan(free_sedan), .free_suv(free_suv)
	);

	// Meter is read at the spot of the trip in flight
	fee_meter_bank #(.N_FLOORS(N_FLOORS)) meters0 (
		.clock(clock), .reset(reset), .occupancy(occupancy), .query(trip.spot),
		.fee(meter_fee)
	);

	elevator_controller #(.N_FLOORS(N_FLOORS)) elev0 (
		.clock(clock), .reset(reset), .head_order(head_order), .head_valid(head_valid),
		.found(found), .spot(alloc_spot), .fee_in(meter_fee), .pop(pop), .park(park),
		.pick(pick), .trip(trip), .busy(busy), .reject(reject),
		.current_floor(current_floor), .car_out(car_out), .exit_plate(exit_plate), .fee(fee)
	);

endmodule

// File: verilog/elevator_controller.sv
/* Elevator trip FSM: accepts or rejects the head order, climbs to the spot,
   parks or picks the car, and returns to floor 0 to release it */
`timescale 1ns/1ps

module elevator_controller #(
	parameter int N_FLOORS = 8
) (
	input  logic                clock,
	input  logic                reset,
	input  lot_pkg::order_t     head_order,
	input  logic                head_valid,
	input  logic                found,
	input  lot_pkg::spot_t      spot,
	input  lot_pkg::fee_t       fee_in,
	output logic                pop,
	output logic                park,
	output logic                pick,
	output elevator_pkg::trip_t trip,
	output logic                busy,
	output logic                reject,
	output lot_pkg::floor_t     current_floor,
	output logic                car_out,
	output lot_pkg::plate_t     exit_plate,
	output lot_pkg::fee_t       fee
);

	localparam lot_pkg::floor_t TOP_FLOOR = lot_pkg::floor_t'(N_FLOORS - 1);

	elevator_pkg::elev_state_t state;
	lot_pkg::fee_t             fee_q;
	logic                      accept;
	logic                      at_target;

	// Orders are only taken while parked at floor 0
	assign pop    = (state == elevator_pkg::idle) && head_valid;
	assign accept = pop && found;
	assign reject = pop && !found;

	// Top floor guard keeps the car inside the tower
	assign at_target = (current_floor == trip.spot.floor) || (current_floor == TOP_FLOOR);

	assign park = (state == elevator_pkg::rise) && at_target && (trip.kind == lot_pkg::order_in);
	assign pick = (state == elevator_pkg::rise) && at_target && (trip.kind == lot_pkg::order_out);

	assign busy = (state != elevator_pkg::idle);
	assign car_out = (state == elevator_pkg::lower) && (current_floor == '0) &&
	                 (trip.kind == lot_pkg::order_out);
	assign exit_plate = trip.plate;
	assign fee        = fee_q;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state         <= elevator_pkg::idle;
			current_floor <= '0;
		end else begin
			case (state)
				elevator_pkg::idle: begin
					if (accept)
						state <= elevator_pkg::rise;
				end
				elevator_pkg::rise: begin
					if (at_target) begin
						// Spot served this cycle, start back down at once
						state         <= elevator_pkg::lower;
						current_floor <= current_floor - 1'b1;
					end else begin
						current_floor <= current_floor + 1'b1;
					end
				end
				elevator_pkg::lower: begin
					if (current_floor == '0)
						state <= elevator_pkg::idle;  // car_out fires on this cycle
					else
						current_floor <= current_floor - 1'b1;
				end
				default: state <= elevator_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			trip <= '{kind: head_order.kind, plate: head_order.plate, spot: spot};
		if (pick)
			fee_q <= fee_in;  // Meter value as of the pick cycle
	end

endmodule

// File: verilog/fee_meter_bank.sv
/* Saturating fee meter per spot, running while the spot is occupied,
   and a read-out mux selected by spot */
`timescale 1ns/1ps

module fee_meter_bank #(
	parameter int N_FLOORS = 8
) (
	input  logic                             clock,
	input  logic                             reset,
	input  lot_pkg::plate_t [2*N_FLOORS-1:0] occupancy,
	input  lot_pkg::spot_t                   query,
	output lot_pkg::fee_t                    fee
);

	lot_pkg::fee_t meter [2*N_FLOORS];

	for (genvar s = 0; s < 2*N_FLOORS; s++) begin : g_meter
		lot_pkg::fee_t count;
		logic          was_occupied;
		logic          occupied;
		logic [1:0]    rate;
		logic [8:0]    sum;

		assign occupied = (occupancy[s] != '0);
		assign rate = (occupancy[s][15:12] == lot_pkg::HANDICAP_NIBBLE) ? 2'd0 :
		              (occupancy[s][15:12] == lot_pkg::HYBRID_NIBBLE)   ? 2'd1 : 2'd2;
		assign sum = {1'b0, count} + {7'd0, rate};  // Carry out means saturate

		always_ff @(posedge clock or posedge reset) begin
			if (reset) begin
				count        <= '0;
				was_occupied <= 1'b0;
			end else begin
				was_occupied <= occupied;
				if (occupied && !was_occupied)
					count <= '0;  // New car, fresh meter
				else if (occupied)
					count <= sum[8] ? lot_pkg::FEE_MAX : sum[7:0];
			end
		end

		assign meter[s] = count;
	end

	assign fee = meter[{query.floor, query.side}];

endmodule

// File: verilog/slot_allocator.sv
/* Spot occupancy register with free counts, lowest-floor spot choice
   for incoming cars and plate lookup for outgoing cars */
`timescale 1ns/1ps

module slot_allocator #(
	parameter int N_FLOORS = 8
) (
	input  logic                                clock,
	input  logic                                reset,
	input  lot_pkg::order_t                     request,
	input  logic                                park,
	input  logic                                pick,
	input  elevator_pkg::trip_t                 trip,
	output logic                                found,
	output lot_pkg::spot_t                      spot,
	output lot_pkg::plate_t [2*N_FLOORS-1:0]    occupancy,
	output logic [3:0]                          free_sedan,
	output logic [3:0]                          free_suv
);

	logic [3:0] trip_idx;

	assign trip_idx = trip.spot;  // Spot code doubles as array index

	// Floor 0 entries are never written and stay empty
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			occupancy <= '0;
		end else if (park) begin
			occupancy[trip_idx] <= trip.plate;
		end else if (pick) begin
			occupancy[trip_idx] <= '0;
		end
	end

	// Spot choice for the order at the head of the queue
	always_comb begin
		found = 1'b0;
		spot  = '0;
		if (request.plate != '0) begin
			if (request.kind == lot_pkg::order_in) begin
				// Scan top down so the lowest floor is the last one to win
				for (int f = N_FLOORS - 1; f >= 1; f--) begin
					if (f[0] == request.plate[0]) begin  // Even plates on even floors
						if (occupancy[2*f+1] == '0) begin
							found      = 1'b1;
							spot.floor = lot_pkg::floor_t'(f);
							spot.side  = 1'b1;
						end
						if (occupancy[2*f] == '0) begin  // Left beats right
							found      = 1'b1;
							spot.floor = lot_pkg::floor_t'(f);
							spot.side  = 1'b0;
						end
					end
				end
			end else begin
				for (int s = 2; s < 2*N_FLOORS; s++) begin
					if (occupancy[s] == request.plate) begin
						found = 1'b1;
						spot  = lot_pkg::spot_t'(4'(s));
					end
				end
			end
		end
	end

	// Empty spots per vehicle class
	always_comb begin
		free_sedan = '0;
		free_suv   = '0;
		for (int f = 1; f < N_FLOORS; f++) begin
			for (int side = 0; side < 2; side++) begin
				if (occupancy[2*f+side] == '0) begin
					if (f[0])
						free_suv = free_suv + 4'd1;
					else
						free_sedan = free_sedan + 4'd1;
				end
			end
		end
	end

endmodule

// File: verilog/order_queue.sv
/* Show-ahead circular queue holding pending in and out orders */
`timescale 1ns/1ps

module order_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            push,
	input  lot_pkg::order_t push_order,
	input  logic            pop,
	output lot_pkg::order_t head_order,
	output logic            head_valid,
	output logic            full
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W:0] DEPTH_COUNT = (PTR_W+1)'(QUEUE_DEPTH);

	lot_pkg::order_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] rd_ptr, wr_ptr;  // Wrap on their own, depth is a power of two
	logic [PTR_W:0]   count;
	logic             do_push, do_pop;

	assign full       = (count == DEPTH_COUNT);
	assign head_valid = (count != '0);
	assign head_order = mem[rd_ptr];  // Oldest order shown without a read cycle
	assign do_push    = push && !full;  // Strobe is lost when full
	assign do_pop     = pop && head_valid;

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_order;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

// File: verilog/elevator_pkg.sv
/* Elevator FSM state encoding and the trip record */
package elevator_pkg;

	typedef enum logic [1:0] {
		idle  = 2'd0,  // At floor 0, waiting for an order
		rise  = 2'd1,
		lower = 2'd2
	} elev_state_t;

	// Order accepted for the trip in flight and its target spot
	typedef struct packed {
		lot_pkg::order_kind_t kind;
		lot_pkg::plate_t      plate;
		lot_pkg::spot_t       spot;
	} trip_t;

endpackage

// File: verilog/lot_pkg.sv
/* Lot types: plates, floors, spots, orders and fees,
   plus the plate class codes and the fee ceiling */
package lot_pkg;

	// A plate of zero marks an empty spot
	typedef logic [15:0] plate_t;

	typedef logic [2:0] floor_t;

	// Spot code is {floor, side}, matching the 4-bit place code
	typedef struct packed {
		floor_t floor;
		logic   side;  // 0 left, 1 right
	} spot_t;

	typedef enum logic {
		order_in  = 1'b0,
		order_out = 1'b1
	} order_kind_t;

	typedef struct packed {
		order_kind_t kind;
		plate_t      plate;
	} order_t;

	typedef logic [7:0] fee_t;

	// Top nibble of the plate selects the fee class
	localparam logic [3:0] HANDICAP_NIBBLE = 4'd9;  // Free of charge
	localparam logic [3:0] HYBRID_NIBBLE   = 4'd8;  // One unit per cycle

	localparam fee_t FEE_MAX = 8'd255;

endpackage
